//--- include/trace_consts.svh
// Retirement trace constants: datapath and tag widths, lane depths and reorder queue length
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

// Operand and result width of every lane
`define TRACE_DATA_WIDTH 32

// Tag carried by each instruction from issue to its trace record
`define TRACE_TAG_WIDTH 8

// Depth of each functional lane in clock edges
`define ALU_LATENCY 1
`define STORE_LATENCY 2
`define MUL_LATENCY 3

// One queue slot per cycle of the deepest lane
`define REORDER_LEN 3

`endif

//--- verilog/isa_pkg.sv
// Instruction-side types shared by the issue stage and the functional lanes
`default_nettype none

`include "trace_consts.svh"

package isa_pkg;

    typedef enum logic [2:0]
    {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL,
        OP_STORE
    } opcode_t;

    typedef enum logic
    {
        SIZE_BYTE,
        SIZE_WORD
    } store_size_t;

    // One instruction as it leaves the issue register
    typedef struct packed
    {
        logic [`TRACE_TAG_WIDTH-1:0] tag;
        opcode_t op;
        store_size_t size;
        logic [4:0] dest;
        logic [`TRACE_DATA_WIDTH-1:0] src_a;
        logic [`TRACE_DATA_WIDTH-1:0] src_b;
        // Signed byte offset, only meaningful for stores
        logic signed [11:0] imm;
    } instr_t;

endpackage

`default_nettype wire

//--- verilog/trace_pkg.sv
// Trace-side types: event kinds and the record that leaves the reorder queue
`default_nettype none

`include "trace_consts.svh"

package trace_pkg;

    typedef enum logic [1:0]
    {
        EV_NONE,
        EV_REG_WRITE,
        EV_STORE
    } event_kind_t;

    // Register write layout of the payload word
    typedef struct packed
    {
        logic [4:0] dest;
        logic [`TRACE_DATA_WIDTH-1:0] value;
        // Fills out the width of the store view
        logic [30:0] pad;
    } reg_write_view_t;

    // Store layout of the payload word
    typedef struct packed
    {
        logic [`TRACE_DATA_WIDTH-1:0] addr;
        logic [3:0] mask;
        logic [`TRACE_DATA_WIDTH-1:0] data;
    } store_view_t;

    // The kind field of the event selects which view is valid
    typedef union packed
    {
        reg_write_view_t reg_write;
        store_view_t store;
    } trace_payload_u;

    typedef struct packed
    {
        event_kind_t kind;
        logic [`TRACE_TAG_WIDTH-1:0] tag;
        trace_payload_u payload;
    } trace_event_t;

endpackage

`default_nettype wire

//--- verilog/issue_stage.sv
// Issue register that accepts instructions and decodes the opcode into a lane select
`default_nettype none
`timescale 1ns/100ps

module issue_stage
(
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,

    input wire logic in_valid,
    output logic in_ready,
    input wire isa_pkg::instr_t in_instr,

    output isa_pkg::instr_t issued,
    output logic alu_go,
    output logic store_go,
    output logic mul_go
);

    // The whole pipeline holds together, so the input can only move when nothing stalls
    assign in_ready = !stall;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            alu_go <= 1'b0;
            store_go <= 1'b0;
            mul_go <= 1'b0;
        end
        else if (!stall)
        begin
            alu_go <= 1'b0;
            store_go <= 1'b0;
            mul_go <= 1'b0;
            if (in_valid)
            begin
                case (in_instr.op)
                    isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_XOR:
                        alu_go <= 1'b1;
                    isa_pkg::OP_STORE:
                        store_go <= 1'b1;
                    isa_pkg::OP_MUL:
                        mul_go <= 1'b1;
                    default:
                        ;
                endcase
            end
        end
    end

    // Instruction fields carry no reset, the go bits qualify them
    always_ff @(posedge clk)
    begin
        if (!stall && in_valid)
            issued <= in_instr;
    end

    // Two lanes started from one instruction would put two events in the queue for one tag
    one_lane_per_instr: assert property (@(posedge clk) disable iff (reset)
        $onehot0({alu_go, store_go, mul_go}))
        else $error("issue_stage: more than one lane selected");

endmodule

`default_nettype wire

//--- verilog/alu_lane.sv
// Single-stage integer lane for add, sub and xor that emits register write events
`default_nettype none
`timescale 1ns/100ps

`include "trace_consts.svh"

module alu_lane
(
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,
    input wire logic go,
    input wire isa_pkg::instr_t instr,
    output trace_pkg::trace_event_t result
);

    logic [`TRACE_DATA_WIDTH-1:0] alu_value;
    logic valid_q;
    logic [`TRACE_TAG_WIDTH-1:0] tag_q;
    logic [4:0] dest_q;
    logic [`TRACE_DATA_WIDTH-1:0] value_q;

    always_comb
    begin
        case (instr.op)
            isa_pkg::OP_ADD: alu_value = instr.src_a + instr.src_b;
            isa_pkg::OP_SUB: alu_value = instr.src_a - instr.src_b;
            isa_pkg::OP_XOR: alu_value = instr.src_a ^ instr.src_b;
            default: alu_value = '0;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            valid_q <= 1'b0;
        else if (!stall)
            valid_q <= go;
    end

    always_ff @(posedge clk)
    begin
        if (!stall && go)
        begin
            tag_q <= instr.tag;
            dest_q <= instr.dest;
            value_q <= alu_value;
        end
    end

    always_comb
    begin
        result.kind = valid_q ? trace_pkg::EV_REG_WRITE : trace_pkg::EV_NONE;
        result.tag = tag_q;
        result.payload.reg_write.dest = dest_q;
        result.payload.reg_write.value = value_q;
        result.payload.reg_write.pad = '0;
    end

endmodule

`default_nettype wire

//--- verilog/store_lane.sv
// Two-stage store lane: address generation, then alignment, byte mask and data placement
`default_nettype none
`timescale 1ns/100ps

`include "trace_consts.svh"

module store_lane
(
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,
    input wire logic go,
    input wire isa_pkg::instr_t instr,
    output trace_pkg::trace_event_t result
);

    logic s1_valid;
    logic [`TRACE_TAG_WIDTH-1:0] s1_tag;
    logic [`TRACE_DATA_WIDTH-1:0] s1_addr;
    isa_pkg::store_size_t s1_size;
    logic [`TRACE_DATA_WIDTH-1:0] s1_data;
    logic s2_valid;
    logic [`TRACE_TAG_WIDTH-1:0] s2_tag;
    logic [`TRACE_DATA_WIDTH-1:0] s2_addr;
    logic [3:0] s2_mask;
    logic [`TRACE_DATA_WIDTH-1:0] s2_data;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else if (!stall)
        begin
            s1_valid <= go;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            // Stage 1 adds the sign-extended offset to the base
            s1_tag <= instr.tag;
            s1_addr <= instr.src_a + {{(`TRACE_DATA_WIDTH - 12){instr.imm[11]}}, instr.imm};
            s1_size <= instr.size;
            s1_data <= instr.src_b;

            // Stage 2 reports the word address with byte lanes selected by the mask
            s2_tag <= s1_tag;
            s2_addr <= {s1_addr[`TRACE_DATA_WIDTH-1:2], 2'b00};
            if (s1_size == isa_pkg::SIZE_BYTE)
            begin
                s2_mask <= 4'b0001 << s1_addr[1:0];
                s2_data <= {4{s1_data[7:0]}};
            end
            else
            begin
                s2_mask <= 4'b1111;
                s2_data <= s1_data;
            end
        end
    end

    always_comb
    begin
        result.kind = s2_valid ? trace_pkg::EV_STORE : trace_pkg::EV_NONE;
        result.tag = s2_tag;
        result.payload.store.addr = s2_addr;
        result.payload.store.mask = s2_mask;
        result.payload.store.data = s2_data;
    end

    // Word stores are expected aligned by the issuer, the mask has no way to express a split
    word_store_aligned: assert property (@(posedge clk) disable iff (reset)
        s1_valid && s1_size == isa_pkg::SIZE_WORD |-> s1_addr[1:0] == 2'b00)
        else $error("store_lane: misaligned word store, addr %h", s1_addr);

endmodule

`default_nettype wire

//--- verilog/mul_lane.sv
// Three-stage multiply lane that builds the low product word from partial products
`default_nettype none
`timescale 1ns/100ps

`include "trace_consts.svh"

module mul_lane
(
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,
    input wire logic go,
    input wire isa_pkg::instr_t instr,
    output trace_pkg::trace_event_t result
);

    localparam int HALF = `TRACE_DATA_WIDTH / 2;

    logic [HALF-1:0] a_lo;
    logic [HALF-1:0] a_hi;
    logic [HALF-1:0] b_lo;
    logic [HALF-1:0] b_hi;
    logic [2:0] valid_q;
    logic [`TRACE_TAG_WIDTH-1:0] tag_q[3];
    logic [4:0] dest_q[3];
    logic [`TRACE_DATA_WIDTH-1:0] s1_ll;
    logic [HALF-1:0] s1_lh;
    logic [HALF-1:0] s1_hl;
    logic [`TRACE_DATA_WIDTH-1:0] s2_ll;
    logic [HALF-1:0] s2_cross;
    logic [`TRACE_DATA_WIDTH-1:0] s3_value;

    assign a_lo = instr.src_a[HALF-1:0];
    assign a_hi = instr.src_a[`TRACE_DATA_WIDTH-1:HALF];
    assign b_lo = instr.src_b[HALF-1:0];
    assign b_hi = instr.src_b[`TRACE_DATA_WIDTH-1:HALF];

    // Each stage holds its own multiply, so up to three can be in flight
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            valid_q <= '0;
        else if (!stall)
            valid_q <= {valid_q[1:0], go};
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            tag_q[0] <= instr.tag;
            dest_q[0] <= instr.dest;
            for (int i = 1; i < 3; i++)
            begin
                tag_q[i] <= tag_q[i - 1];
                dest_q[i] <= dest_q[i - 1];
            end

            // Only the low half of each cross product reaches the low result word
            s1_ll <= {{HALF{1'b0}}, a_lo} * {{HALF{1'b0}}, b_lo};
            s1_lh <= a_lo * b_hi;
            s1_hl <= a_hi * b_lo;

            s2_ll <= s1_ll;
            s2_cross <= s1_lh + s1_hl;

            s3_value <= s2_ll + {s2_cross, {HALF{1'b0}}};
        end
    end

    always_comb
    begin
        result.kind = valid_q[2] ? trace_pkg::EV_REG_WRITE : trace_pkg::EV_NONE;
        result.tag = tag_q[2];
        result.payload.reg_write.dest = dest_q[2];
        result.payload.reg_write.value = s3_value;
        result.payload.reg_write.pad = '0;
    end

endmodule

`default_nettype wire

//--- verilog/trace_reorder_queue.sv
// Shift queue that inserts lane events by latency so trace records leave in issue order
`default_nettype none
`timescale 1ns/100ps

`include "trace_consts.svh"

module trace_reorder_queue
(
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,

    input wire trace_pkg::trace_event_t alu_event,
    input wire trace_pkg::trace_event_t store_event,
    input wire trace_pkg::trace_event_t mul_event,

    output logic trace_valid,
    output trace_pkg::trace_event_t trace_event
);

    // A lane of latency L lands where it still has REORDER_LEN - L shifts to go
    localparam int ALU_SLOT = `REORDER_LEN - `ALU_LATENCY;
    localparam int STORE_SLOT = `REORDER_LEN - `STORE_LATENCY;
    localparam int MUL_SLOT = `REORDER_LEN - `MUL_LATENCY;

    trace_pkg::event_kind_t slot_kind[`REORDER_LEN];
    logic [`TRACE_TAG_WIDTH-1:0] slot_tag[`REORDER_LEN];
    trace_pkg::trace_payload_u slot_payload[`REORDER_LEN];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REORDER_LEN; i++)
                slot_kind[i] <= trace_pkg::EV_NONE;
        end
        else if (!stall)
        begin
            for (int i = 0; i < `REORDER_LEN - 1; i++)
                slot_kind[i] <= slot_kind[i + 1];
            slot_kind[`REORDER_LEN - 1] <= trace_pkg::EV_NONE;

            if (mul_event.kind != trace_pkg::EV_NONE)
                slot_kind[MUL_SLOT] <= mul_event.kind;
            if (store_event.kind != trace_pkg::EV_NONE)
                slot_kind[STORE_SLOT] <= store_event.kind;
            if (alu_event.kind != trace_pkg::EV_NONE)
                slot_kind[ALU_SLOT] <= alu_event.kind;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            for (int i = 0; i < `REORDER_LEN - 1; i++)
            begin
                slot_tag[i] <= slot_tag[i + 1];
                slot_payload[i] <= slot_payload[i + 1];
            end

            if (mul_event.kind != trace_pkg::EV_NONE)
            begin
                slot_tag[MUL_SLOT] <= mul_event.tag;
                slot_payload[MUL_SLOT] <= mul_event.payload;
            end
            if (store_event.kind != trace_pkg::EV_NONE)
            begin
                slot_tag[STORE_SLOT] <= store_event.tag;
                slot_payload[STORE_SLOT] <= store_event.payload;
            end
            if (alu_event.kind != trace_pkg::EV_NONE)
            begin
                slot_tag[ALU_SLOT] <= alu_event.tag;
                slot_payload[ALU_SLOT] <= alu_event.payload;
            end
        end
    end

    always_comb
    begin
        trace_event.kind = slot_kind[0];
        trace_event.tag = slot_tag[0];
        trace_event.payload = slot_payload[0];
    end

    assign trace_valid = slot_kind[0] != trace_pkg::EV_NONE;

    // After a shift, slot s holds what was in slot s+1. The ALU slot is the tail and is
    // always free, so only the two deeper lanes can collide
    mul_slot_free: assert property (@(posedge clk) disable iff (reset)
        !stall && mul_event.kind != trace_pkg::EV_NONE
            |-> slot_kind[MUL_SLOT + 1] == trace_pkg::EV_NONE)
        else $error("trace_reorder_queue: multiply event overwrites tag %h",
            slot_tag[MUL_SLOT + 1]);

    store_slot_free: assert property (@(posedge clk) disable iff (reset)
        !stall && store_event.kind != trace_pkg::EV_NONE
            |-> slot_kind[STORE_SLOT + 1] == trace_pkg::EV_NONE)
        else $error("trace_reorder_queue: store event overwrites tag %h",
            slot_tag[STORE_SLOT + 1]);

    // The consumer may sample the head at any point of a stall
    head_stable: assert property (@(posedge clk) disable iff (reset)
        trace_valid && stall |=> $stable(trace_event))
        else $error("trace_reorder_queue: head changed while stalled");

endmodule

`default_nettype wire

//--- verilog/trace_retire_top.sv
// Retirement trace top level: issue, three lanes, reorder queue and the global stall
`default_nettype none
`timescale 1ns/100ps

module trace_retire_top
(
    input wire logic clk,
    input wire logic reset,

    input wire logic in_valid,
    output logic in_ready,
    input wire isa_pkg::instr_t in_instr,

    output logic trace_valid,
    input wire logic trace_ready,
    output trace_pkg::trace_event_t trace_event
);

    logic stall;
    isa_pkg::instr_t issued;
    logic alu_go;
    logic store_go;
    logic mul_go;
    trace_pkg::trace_event_t alu_event;
    trace_pkg::trace_event_t store_event;
    trace_pkg::trace_event_t mul_event;

    // Slot positions assume all lanes advance together, so one refused record
    // freezes the whole pipeline
    assign stall = trace_valid && !trace_ready;

    issue_stage issue_stage_i
    (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_instr(in_instr),
        .issued(issued),
        .alu_go(alu_go),
        .store_go(store_go),
        .mul_go(mul_go)
    );

    alu_lane alu_lane_i
    (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .go(alu_go),
        .instr(issued),
        .result(alu_event)
    );

    store_lane store_lane_i
    (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .go(store_go),
        .instr(issued),
        .result(store_event)
    );

    mul_lane mul_lane_i
    (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .go(mul_go),
        .instr(issued),
        .result(mul_event)
    );

    trace_reorder_queue trace_reorder_queue_i
    (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .alu_event(alu_event),
        .store_event(store_event),
        .mul_event(mul_event),
        .trace_valid(trace_valid),
        .trace_event(trace_event)
    );

endmodule

`default_nettype wire

//--- dv/trace_retire_tb.sv
// Retirement trace testbench with directed and random streams checked against a reference model
`default_nettype none
`timescale 1ns/100ps

`include "trace_consts.svh"

module trace_retire_tb;

    localparam int RESET_CYCLES = 10;
    localparam int DIRECTED_INSTRS = 24;
    localparam int RANDOM_INSTRS = 400;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * (DIRECTED_INSTRS + RANDOM_INSTRS);
    // With trace_ready held high every record in flight leaves well within this
    localparam int DRAIN_CYCLES = 20;

    // How trace_ready is driven in each phase
    localparam int READY_LOW = 0;
    localparam int READY_HIGH = 1;
    localparam int READY_RANDOM = 2;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    isa_pkg::instr_t in_instr;
    logic trace_valid;
    logic trace_ready;
    trace_pkg::trace_event_t trace_event;

    logic [31:0] rand_state;
    int ready_mode;
    logic [`TRACE_TAG_WIDTH-1:0] next_tag;
    int accepted_count;
    int records_seen;
    trace_pkg::trace_event_t expected_q[$];

    trace_retire_top trace_retire_top_i
    (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_instr(in_instr),
        .trace_valid(trace_valid),
        .trace_ready(trace_ready),
        .trace_event(trace_event)
    );

    // 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [67:0] actual,
        input logic [67:0] expected);
        if (actual !== expected)
            fail_run($sformatf("error: %s actual %h expected %h", name, actual, expected));
    endtask

    function automatic int unsigned next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // The low bits of the generator are weak, so a word is built from two upper halves
    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    // Computes the trace record that one instruction should produce
    function automatic trace_pkg::trace_event_t expected_event(input isa_pkg::instr_t instr);
        trace_pkg::trace_event_t ev;
        logic [63:0] product;
        logic [31:0] eff_addr;
        ev = '0;
        ev.tag = instr.tag;
        ev.kind = trace_pkg::EV_REG_WRITE;
        ev.payload.reg_write.dest = instr.dest;
        case (instr.op)
            isa_pkg::OP_ADD: ev.payload.reg_write.value = instr.src_a + instr.src_b;
            isa_pkg::OP_SUB: ev.payload.reg_write.value = instr.src_a - instr.src_b;
            isa_pkg::OP_XOR: ev.payload.reg_write.value = instr.src_a ^ instr.src_b;
            isa_pkg::OP_MUL:
            begin
                product = {32'd0, instr.src_a} * {32'd0, instr.src_b};
                ev.payload.reg_write.value = product[31:0];
            end
            isa_pkg::OP_STORE:
            begin
                eff_addr = instr.src_a + {{20{instr.imm[11]}}, instr.imm};
                ev.kind = trace_pkg::EV_STORE;
                ev.payload = '0;
                ev.payload.store.addr = {eff_addr[31:2], 2'b00};
                if (instr.size == isa_pkg::SIZE_WORD)
                begin
                    ev.payload.store.mask = 4'b1111;
                    ev.payload.store.data = instr.src_b;
                end
                else
                begin
                    case (eff_addr[1:0])
                        2'd0: ev.payload.store.mask = 4'b0001;
                        2'd1: ev.payload.store.mask = 4'b0010;
                        2'd2: ev.payload.store.mask = 4'b0100;
                        default: ev.payload.store.mask = 4'b1000;
                    endcase
                    ev.payload.store.data = {4{instr.src_b[7:0]}};
                end
            end
            default: ev.kind = trace_pkg::EV_NONE;
        endcase
        return ev;
    endfunction

    function automatic isa_pkg::instr_t random_instr();
        isa_pkg::instr_t instr;
        int unsigned r;
        instr = '0;
        r = next_rand();
        case ((r >> 16) % 5)
            0: instr.op = isa_pkg::OP_ADD;
            1: instr.op = isa_pkg::OP_SUB;
            2: instr.op = isa_pkg::OP_XOR;
            3: instr.op = isa_pkg::OP_MUL;
            default: instr.op = isa_pkg::OP_STORE;
        endcase
        r = next_rand();
        instr.dest = 5'(r >> 16);
        instr.size = r[31] ? isa_pkg::SIZE_WORD : isa_pkg::SIZE_BYTE;
        instr.imm = 12'(r >> 19);
        instr.src_a = rand_word();
        instr.src_b = rand_word();
        // Word stores must land on a word boundary
        if (instr.op == isa_pkg::OP_STORE && instr.size == isa_pkg::SIZE_WORD)
        begin
            instr.src_a[1:0] = 2'b00;
            instr.imm[1:0] = 2'b00;
        end
        return instr;
    endfunction

    task automatic drive_ready();
        int unsigned r;
        case (ready_mode)
            READY_LOW: trace_ready = 1'b0;
            READY_HIGH: trace_ready = 1'b1;
            default:
            begin
                r = next_rand();
                trace_ready = ((r >> 16) % 4) != 0;
            end
        endcase
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            drive_ready();
        end
    endtask

    task automatic send_instr(input isa_pkg::instr_t instr);
        logic accepted;
        instr.tag = next_tag;
        in_valid = 1'b1;
        in_instr = instr;
        accepted = 1'b0;
        while (!accepted)
        begin
            // Handshake inputs are stable at the falling edge
            @(negedge clk);
            accepted = in_ready;
            if (accepted)
            begin
                expected_q.push_back(expected_event(instr));
                accepted_count++;
                next_tag++;
            end
            @(posedge clk);
            #1;
            drive_ready();
        end
        in_valid = 1'b0;
    endtask

    task automatic send_reg_op(input isa_pkg::opcode_t op, input logic [4:0] dest,
        input logic [31:0] a, input logic [31:0] b);
        isa_pkg::instr_t instr;
        instr = '0;
        instr.op = op;
        instr.dest = dest;
        instr.src_a = a;
        instr.src_b = b;
        send_instr(instr);
    endtask

    task automatic send_store(input isa_pkg::store_size_t size, input logic [31:0] base,
        input logic [11:0] imm, input logic [31:0] data);
        isa_pkg::instr_t instr;
        instr = '0;
        instr.op = isa_pkg::OP_STORE;
        instr.size = size;
        instr.src_a = base;
        instr.src_b = data;
        instr.imm = imm;
        send_instr(instr);
    endtask

    task automatic compare_record(input trace_pkg::trace_event_t actual,
        input trace_pkg::trace_event_t expected);
        check_value("trace_event.kind", 68'(actual.kind), 68'(expected.kind));
        check_value("trace_event.tag", 68'(actual.tag), 68'(expected.tag));
        if (expected.kind == trace_pkg::EV_STORE)
        begin
            check_value("trace_event.store.addr", 68'(actual.payload.store.addr),
                68'(expected.payload.store.addr));
            check_value("trace_event.store.mask", 68'(actual.payload.store.mask),
                68'(expected.payload.store.mask));
            check_value("trace_event.store.data", 68'(actual.payload.store.data),
                68'(expected.payload.store.data));
        end
        else
        begin
            check_value("trace_event.reg_write.dest", 68'(actual.payload.reg_write.dest),
                68'(expected.payload.reg_write.dest));
            check_value("trace_event.reg_write.value", 68'(actual.payload.reg_write.value),
                68'(expected.payload.reg_write.value));
            check_value("trace_event.reg_write.pad", 68'(actual.payload.reg_write.pad),
                68'(expected.payload.reg_write.pad));
        end
    endtask

    // The scoreboard takes one expected record off the queue per output transfer
    initial
    begin : compare_records
        trace_pkg::trace_event_t expected;
        records_seen = 0;
        forever
        begin
            @(negedge clk);
            if (!reset)
            begin
                check_value("in_ready", 68'(in_ready), 68'(!(trace_valid && !trace_ready)));
                if (trace_valid && trace_ready)
                begin
                    if (expected_q.size() == 0)
                        fail_run("A trace record came out with no accepted instruction behind it");
                    else
                    begin
                        expected = expected_q.pop_front();
                        compare_record(trace_event, expected);
                        records_seen++;
                    end
                end
            end
        end
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("Timeout after %0d cycles with %0d trace records still missing",
            WATCHDOG_CYCLES, expected_q.size()));
    end

    initial
    begin : stimulus
        int unsigned r;
        int drain_wait;
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        trace_ready = 1'b0;
        rand_state = 32'd31541;
        ready_mode = READY_LOW;
        next_tag = '0;
        accepted_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Empty pipeline must not stall even with the consumer refusing
        repeat (5)
        begin
            @(negedge clk);
            check_value("trace_valid", 68'(trace_valid), 68'd0);
            check_value("in_ready", 68'(in_ready), 68'd1);
            @(posedge clk);
            #1;
            drive_ready();
        end
        ready_mode = READY_HIGH;
        drive_ready();

        send_reg_op(isa_pkg::OP_ADD, 5'd1, 32'd5, 32'd7);
        send_reg_op(isa_pkg::OP_ADD, 5'd2, 32'hffff_ffff, 32'd1);
        send_reg_op(isa_pkg::OP_SUB, 5'd3, 32'd3, 32'd5);
        send_reg_op(isa_pkg::OP_SUB, 5'd4, 32'h8000_0000, 32'd1);
        send_reg_op(isa_pkg::OP_XOR, 5'd31, 32'hf0f0_f0f0, 32'hff00_ff00);
        idle_cycles(4);

        // Back-to-back multiplies keep all three stages busy
        send_reg_op(isa_pkg::OP_MUL, 5'd5, 32'hffff_ffff, 32'hffff_ffff);
        send_reg_op(isa_pkg::OP_MUL, 5'd6, 32'h1234_5678, 32'h9abc_def0);
        send_reg_op(isa_pkg::OP_MUL, 5'd7, 32'd3, 32'd5);
        send_reg_op(isa_pkg::OP_MUL, 5'd8, 32'h0001_0000, 32'h0001_0000);
        send_reg_op(isa_pkg::OP_MUL, 5'd9, 32'hdead_beef, 32'd0);
        idle_cycles(4);

        send_store(isa_pkg::SIZE_BYTE, 32'h0000_1000, 12'h000, 32'h1234_56a5);
        send_store(isa_pkg::SIZE_BYTE, 32'h0000_1000, 12'h001, 32'h0000_005a);
        send_store(isa_pkg::SIZE_BYTE, 32'h0000_1000, 12'h002, 32'hffff_ff3c);
        send_store(isa_pkg::SIZE_BYTE, 32'h0000_1000, 12'h003, 32'h0000_00c3);
        send_store(isa_pkg::SIZE_BYTE, 32'h0000_1003, 12'hffa, 32'h0000_0077);
        send_store(isa_pkg::SIZE_WORD, 32'h0000_2000, 12'hffc, 32'hcafe_f00d);
        send_store(isa_pkg::SIZE_WORD, 32'h0000_0000, 12'h008, 32'h0bad_cafe);
        idle_cycles(3);

        // Lanes of different depth on consecutive cycles
        send_reg_op(isa_pkg::OP_MUL, 5'd10, 32'h0000_1234, 32'h0000_0100);
        send_reg_op(isa_pkg::OP_ADD, 5'd11, 32'd100, 32'd23);
        send_store(isa_pkg::SIZE_WORD, 32'h0000_3000, 12'h004, 32'h5555_aaaa);
        send_store(isa_pkg::SIZE_BYTE, 32'h0000_4002, 12'h001, 32'h0000_00e1);
        send_reg_op(isa_pkg::OP_MUL, 5'd12, 32'h7fff_ffff, 32'd2);
        send_reg_op(isa_pkg::OP_SUB, 5'd13, 32'd0, 32'd1);
        send_reg_op(isa_pkg::OP_XOR, 5'd14, 32'h0000_ffff, 32'hffff_0000);
        idle_cycles(6);

        ready_mode = READY_RANDOM;
        drive_ready();
        for (int i = 0; i < RANDOM_INSTRS; i++)
        begin
            r = next_rand();
            if (((r >> 16) % 4) == 0)
                idle_cycles(1 + int'((r >> 20) % 3));
            send_instr(random_instr());
        end

        ready_mode = READY_HIGH;
        drive_ready();
        drain_wait = 0;
        while (expected_q.size() != 0 && drain_wait < DRAIN_CYCLES)
        begin
            idle_cycles(1);
            drain_wait++;
        end
        idle_cycles(10);

        if (expected_q.size() != 0)
            fail_run($sformatf("Accepted %0d instructions but saw only %0d trace records",
                accepted_count, records_seen));
        else
        begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
verilog/isa_pkg.sv
verilog/trace_pkg.sv
verilog/issue_stage.sv
verilog/alu_lane.sv
verilog/store_lane.sv
verilog/mul_lane.sv
verilog/trace_reorder_queue.sv
verilog/trace_retire_top.sv
dv/trace_retire_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the retirement trace testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module trace_retire_tb \
    --Mdir obj_dir \
    -f sources.f

# A $fatal in the testbench gives a failing exit status
./obj_dir/Vtrace_retire_tb
